//--- design/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// architectural register file
`define CORE_REG_COUNT 32
`define CORE_REG_ADDR_W 5

// hi/lo contents out of reset
`define CORE_HILO_RESET 32'h0000_0000

`endif

//--- design/core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [63:0] hilo_t;

    // immediate forms reuse the matching register-register op
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MULT,
        OP_MULTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_t;

endpackage

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  core_pkg::word_t     instr,
    input  core_pkg::word_t     rd1,
    input  core_pkg::word_t     rd2,
    input  logic                ex_fwd_write,
    input  core_pkg::reg_addr_t ex_fwd_addr,
    input  core_pkg::word_t     ex_fwd_data,
    output core_pkg::reg_addr_t ra1,
    output core_pkg::reg_addr_t ra2,
    output logic                d_valid,
    output logic                d_write,
    output core_pkg::alu_op_t   d_op,
    output core_pkg::reg_addr_t d_dest,
    output core_pkg::word_t     d_srca,
    output core_pkg::word_t     d_srcb,
    output logic [4:0]          d_shamt
);
    import core_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs_f;
    reg_addr_t   rt_f;
    reg_addr_t   rd_f;
    logic [4:0]  shamt_f;
    logic [15:0] imm;

    alu_op_t     op_n;
    reg_addr_t   dest_n;
    logic        known;
    logic        writes;
    logic        use_imm;
    logic        zero_a;
    word_t       imm_ext;
    word_t       opa;
    word_t       opb;

    assign opcode  = instr[31:26];
    assign rs_f    = instr[25:21];
    assign rt_f    = instr[20:16];
    assign rd_f    = instr[15:11];
    assign shamt_f = instr[10:6];
    assign funct   = instr[5:0];
    assign imm     = instr[15:0];

    assign ra1 = rs_f;
    assign ra2 = rt_f;

    always_comb begin
        op_n    = OP_NONE;
        dest_n  = rd_f;
        known   = 1'b1;
        writes  = 1'b1;
        use_imm = 1'b0;
        zero_a  = 1'b0;
        imm_ext = {{16{imm[15]}}, imm};
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h21: op_n = OP_ADDU;
                    6'h23: op_n = OP_SUBU;
                    6'h24: op_n = OP_AND;
                    6'h25: op_n = OP_OR;
                    6'h26: op_n = OP_XOR;
                    6'h27: op_n = OP_NOR;
                    6'h2a: op_n = OP_SLT;
                    6'h2b: op_n = OP_SLTU;
                    6'h00: op_n = OP_SLL;
                    6'h02: op_n = OP_SRL;
                    6'h03: op_n = OP_SRA;
                    6'h10: op_n = OP_MFHI;
                    6'h12: op_n = OP_MFLO;
                    6'h18: begin
                        op_n   = OP_MULT;
                        writes = 1'b0;
                    end
                    6'h19: begin
                        op_n   = OP_MULTU;
                        writes = 1'b0;
                    end
                    6'h11: begin
                        op_n   = OP_MTHI;
                        writes = 1'b0;
                    end
                    6'h13: begin
                        op_n   = OP_MTLO;
                        writes = 1'b0;
                    end
                    default: known = 1'b0;
                endcase
            end
            6'h09: op_n = OP_ADDU;
            6'h0a: op_n = OP_SLT;
            6'h0b: op_n = OP_SLTU;
            6'h0c: op_n = OP_AND;
            6'h0d: op_n = OP_OR;
            6'h0e: op_n = OP_XOR;
            6'h0f: op_n = OP_OR;
            default: known = 1'b0;
        endcase

        if (opcode != 6'h00) begin
            dest_n  = rt_f;
            use_imm = 1'b1;
        end
        // logical immediates zero-extend
        if (opcode == 6'h0c || opcode == 6'h0d || opcode == 6'h0e) begin
            imm_ext = {16'h0000, imm};
        end
        // lui is an or with zero
        if (opcode == 6'h0f) begin
            imm_ext = {imm, 16'h0000};
            zero_a  = 1'b1;
        end

        if (!known) begin
            op_n   = OP_NONE;
            writes = 1'b0;
        end
    end

    // forward from the instruction one ahead
    assign opa = (ex_fwd_write && ex_fwd_addr == rs_f) ? ex_fwd_data : rd1;
    assign opb = (ex_fwd_write && ex_fwd_addr == rt_f) ? ex_fwd_data : rd2;

    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
            d_write <= 1'b0;
            d_op    <= OP_NONE;
        end else begin
            d_valid <= instr_valid && known;
            d_write <= instr_valid && writes && dest_n != '0;
            d_op    <= instr_valid ? op_n : OP_NONE;
        end
    end

    always_ff @(posedge clk) begin
        d_dest  <= dest_n;
        d_srca  <= zero_a ? '0 : opa;
        d_srcb  <= use_imm ? imm_ext : opb;
        d_shamt <= shamt_f;
    end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                d_valid,
    input  core_pkg::alu_op_t   d_op,
    input  core_pkg::reg_addr_t d_dest,
    input  logic                d_write,
    input  core_pkg::word_t     d_srca,
    input  core_pkg::word_t     d_srcb,
    input  logic [4:0]          d_shamt,
    input  core_pkg::word_t     hi_value,
    input  core_pkg::word_t     lo_value,
    output logic                ex_fwd_write,
    output core_pkg::reg_addr_t ex_fwd_addr,
    output core_pkg::word_t     ex_fwd_data,
    output logic                e_write,
    output core_pkg::reg_addr_t e_dest,
    output core_pkg::word_t     e_data,
    output logic                e_hi_write,
    output logic                e_lo_write,
    output core_pkg::word_t     e_hi,
    output core_pkg::word_t     e_lo
);
    import core_pkg::*;

    word_t result;
    hilo_t product;
    word_t hi_n;
    word_t lo_n;
    logic  hi_w;
    logic  lo_w;

    always_comb begin
        case (d_op)
            OP_ADDU: result = d_srca + d_srcb;
            OP_SUBU: result = d_srca - d_srcb;
            OP_AND:  result = d_srca & d_srcb;
            OP_OR:   result = d_srca | d_srcb;
            OP_XOR:  result = d_srca ^ d_srcb;
            OP_NOR:  result = ~(d_srca | d_srcb);
            OP_SLT:  result = {31'b0, $signed(d_srca) < $signed(d_srcb)};
            OP_SLTU: result = {31'b0, d_srca < d_srcb};
            OP_SLL:  result = d_srcb << d_shamt;
            OP_SRL:  result = d_srcb >> d_shamt;
            OP_SRA:  result = $signed(d_srcb) >>> d_shamt;
            OP_MFHI: result = hi_value;
            OP_MFLO: result = lo_value;
            default: result = '0;
        endcase
    end

    // low 64 bits of the extended product
    always_comb begin
        if (d_op == OP_MULT) begin
            product = {{32{d_srca[31]}}, d_srca} * {{32{d_srcb[31]}}, d_srcb};
        end else begin
            product = {32'h0, d_srca} * {32'h0, d_srcb};
        end
    end

    always_comb begin
        hi_w = d_op inside {OP_MULT, OP_MULTU, OP_MTHI};
        lo_w = d_op inside {OP_MULT, OP_MULTU, OP_MTLO};
        hi_n = (d_op == OP_MTHI) ? d_srca : product[63:32];
        lo_n = (d_op == OP_MTLO) ? d_srca : product[31:0];
    end

    assign ex_fwd_write = d_write;
    assign ex_fwd_addr  = d_dest;
    assign ex_fwd_data  = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            e_write    <= 1'b0;
            e_hi_write <= 1'b0;
            e_lo_write <= 1'b0;
        end else begin
            e_write    <= d_write;
            e_hi_write <= d_valid && hi_w;
            e_lo_write <= d_valid && lo_w;
        end
    end

    always_ff @(posedge clk) begin
        e_dest <= d_dest;
        e_data <= result;
        e_hi   <= hi_n;
        e_lo   <= lo_n;
    end

endmodule

`default_nettype wire

//--- design/mini_core.sv
`default_nettype none

module mini_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  core_pkg::word_t     instr,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data
);
    import core_pkg::*;

    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;
    logic      wen;
    reg_addr_t wa;
    word_t     wd;

    logic      ex_fwd_write;
    reg_addr_t ex_fwd_addr;
    word_t     ex_fwd_data;

    logic      d_valid;
    logic      d_write;
    alu_op_t   d_op;
    reg_addr_t d_dest;
    word_t     d_srca;
    word_t     d_srcb;
    logic [4:0] d_shamt;

    logic      e_write;
    reg_addr_t e_dest;
    word_t     e_data;
    logic      e_hi_write;
    logic      e_lo_write;
    word_t     e_hi;
    word_t     e_lo;
    word_t     hi_value;
    word_t     lo_value;

    reg_file u_reg_file (
        .clk, .reset,
        .ra1, .ra2,
        .wen, .wa, .wd,
        .rd1, .rd2
    );

    decode_stage u_decode (
        .clk, .reset,
        .instr_valid, .instr,
        .rd1, .rd2,
        .ex_fwd_write, .ex_fwd_addr, .ex_fwd_data,
        .ra1, .ra2,
        .d_valid, .d_write, .d_op, .d_dest,
        .d_srca, .d_srcb, .d_shamt
    );

    execute_stage u_execute (
        .clk, .reset,
        .d_valid, .d_op, .d_dest, .d_write,
        .d_srca, .d_srcb, .d_shamt,
        .hi_value, .lo_value,
        .ex_fwd_write, .ex_fwd_addr, .ex_fwd_data,
        .e_write, .e_dest, .e_data,
        .e_hi_write, .e_lo_write, .e_hi, .e_lo
    );

    result_stage u_result (
        .clk, .reset,
        .e_write, .e_dest, .e_data,
        .e_hi_write, .e_lo_write, .e_hi, .e_lo,
        .wen, .wa, .wd,
        .wb_valid, .wb_addr, .wb_data,
        .hi_value, .lo_value
    );

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

`include "core_cfg.svh"

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::reg_addr_t ra1,
    input  core_pkg::reg_addr_t ra2,
    input  logic               wen,
    input  core_pkg::reg_addr_t wa,
    input  core_pkg::word_t    wd,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2
);
    import core_pkg::*;

    // entry zero is not stored
    word_t regs [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-through so decode sees the result stage this cycle
    assign rd1 = (ra1 == '0) ? '0 : (wen && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (wen && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

//--- design/result_stage.sv
`default_nettype none

`include "core_cfg.svh"

module result_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                e_write,
    input  core_pkg::reg_addr_t e_dest,
    input  core_pkg::word_t     e_data,
    input  logic                e_hi_write,
    input  logic                e_lo_write,
    input  core_pkg::word_t     e_hi,
    input  core_pkg::word_t     e_lo,
    output logic                wen,
    output core_pkg::reg_addr_t wa,
    output core_pkg::word_t     wd,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data,
    output core_pkg::word_t     hi_value,
    output core_pkg::word_t     lo_value
);
    import core_pkg::*;

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= `CORE_HILO_RESET;
            lo_q <= `CORE_HILO_RESET;
        end else begin
            if (e_hi_write) begin
                hi_q <= e_hi;
            end
            if (e_lo_write) begin
                lo_q <= e_lo;
            end
        end
    end

    // pending write wins for mfhi/mflo right behind
    assign hi_value = e_hi_write ? e_hi : hi_q;
    assign lo_value = e_lo_write ? e_lo : lo_q;

    assign wen      = e_write;
    assign wa       = e_dest;
    assign wd       = e_data;
    assign wb_valid = e_write;
    assign wb_addr  = e_dest;
    assign wb_data  = e_data;

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/core_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/mini_core.sv
tests/clock_gen.sv
tests/core_sva.sv
tests/core_tb.sv

//--- tests/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/core_sva.sv
`default_nettype none

module core_sva (
    input logic                clk,
    input logic                reset,
    input logic                wb_valid,
    input core_pkg::reg_addr_t wb_addr,
    input core_pkg::word_t     wb_data
);
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    // read by the testbench at the end of each cycle
    int fail_count = 0;

    // pipeline comes out of reset empty
    idle_after_reset: assert property (
        @(posedge clk) reset |=> !wb_valid
    ) else begin
        $error("wb_valid high in the cycle after reset");
        fail_count++;
    end

    // r0 writes are squashed in decode
    no_zero_write: assert property (
        @(posedge clk) disable iff (reset) wb_valid |-> wb_addr != '0
    ) else begin
        $error("result port reports a write to register zero");
        fail_count++;
    end

    known_data: assert property (
        @(posedge clk) disable iff (reset) wb_valid |-> !$isunknown(wb_data)
    ) else begin
        $error("wb_data unknown while wb_valid is high");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- tests/core_tb.sv
`default_nettype none

`include "core_cfg.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int N = 42;

    localparam logic [5:0] F_SLL   = 6'h00;
    localparam logic [5:0] F_SRL   = 6'h02;
    localparam logic [5:0] F_SRA   = 6'h03;
    localparam logic [5:0] F_MFHI  = 6'h10;
    localparam logic [5:0] F_MTHI  = 6'h11;
    localparam logic [5:0] F_MFLO  = 6'h12;
    localparam logic [5:0] F_MTLO  = 6'h13;
    localparam logic [5:0] F_MULT  = 6'h18;
    localparam logic [5:0] F_MULTU = 6'h19;
    localparam logic [5:0] F_ADDU  = 6'h21;
    localparam logic [5:0] F_SUBU  = 6'h23;
    localparam logic [5:0] F_AND   = 6'h24;
    localparam logic [5:0] F_OR    = 6'h25;
    localparam logic [5:0] F_XOR   = 6'h26;
    localparam logic [5:0] F_NOR   = 6'h27;
    localparam logic [5:0] F_SLT   = 6'h2a;
    localparam logic [5:0] F_SLTU  = 6'h2b;
    localparam logic [5:0] O_ADDIU = 6'h09;
    localparam logic [5:0] O_SLTI  = 6'h0a;
    localparam logic [5:0] O_SLTIU = 6'h0b;
    localparam logic [5:0] O_ANDI  = 6'h0c;
    localparam logic [5:0] O_ORI   = 6'h0d;
    localparam logic [5:0] O_XORI  = 6'h0e;
    localparam logic [5:0] O_LUI   = 6'h0f;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;

    word_t     instr_tab [N];
    logic      valid_tab [N];
    logic      exp_v_tab [N];
    reg_addr_t exp_a_tab [N];
    word_t     exp_d_tab [N];
    int        entry_count = 0;
    int        idx_q [$];
    int        due_q [$];
    int        cycle = 0;
    int        cycle_limit = 0;

    clock_gen u_clock_gen (
        .clk(clk),
        .reset(reset)
    );

    mini_core u_mini_core (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .wb_valid(wb_valid),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

    bind mini_core core_sva u_core_sva (
        .clk(clk),
        .reset(reset),
        .wb_valid(wb_valid),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

    function automatic word_t rtype_word(input logic [4:0] rs, rt, rd, sh,
                                         input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic is_product_op(input word_t w);
        return w[31:26] == 6'h00 && (w[5:0] == F_MULT || w[5:0] == F_MULTU);
    endfunction

    task automatic add_entry(input word_t w, input logic v, input logic ev,
                             input reg_addr_t ea, input word_t ed);
        instr_tab[entry_count] = w;
        valid_tab[entry_count] = v;
        exp_v_tab[entry_count] = ev;
        exp_a_tab[entry_count] = ea;
        exp_d_tab[entry_count] = ed;
        entry_count++;
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // expected values follow MIPS rules from all-zero registers
    task automatic build_table();
        add_entry(rtype_word(0, 0, 1, 0, F_MFHI), 1, 1, 1, `CORE_HILO_RESET);
        add_entry(itype_word(O_ORI, 0, 1, 16'h1234), 1, 1, 1, 32'h0000_1234);
        add_entry(itype_word(O_ADDIU, 0, 2, 16'hfffe), 1, 1, 2, 32'hffff_fffe);
        add_entry(rtype_word(1, 2, 3, 0, F_ADDU), 1, 1, 3, 32'h0000_1232);
        add_entry(rtype_word(3, 1, 4, 0, F_SUBU), 1, 1, 4, 32'hffff_fffe);
        add_entry(rtype_word(4, 1, 5, 0, F_AND), 1, 1, 5, 32'h0000_1234);
        add_entry(rtype_word(5, 2, 6, 0, F_OR), 1, 1, 6, 32'hffff_fffe);
        add_entry(rtype_word(6, 1, 7, 0, F_XOR), 1, 1, 7, 32'hffff_edca);
        add_entry(rtype_word(7, 0, 8, 0, F_NOR), 1, 1, 8, 32'h0000_1235);
        add_entry(rtype_word(2, 1, 9, 0, F_SLT), 1, 1, 9, 32'h0000_0001);
        add_entry(rtype_word(2, 1, 10, 0, F_SLTU), 1, 1, 10, 32'h0000_0000);
        add_entry(itype_word(O_LUI, 0, 11, 16'h8000), 1, 1, 11, 32'h8000_0000);
        add_entry(rtype_word(0, 1, 12, 4, F_SLL), 1, 1, 12, 32'h0001_2340);
        add_entry(rtype_word(0, 11, 13, 3, F_SRL), 1, 1, 13, 32'h1000_0000);
        add_entry(rtype_word(0, 11, 14, 3, F_SRA), 1, 1, 14, 32'hf000_0000);
        add_entry(itype_word(O_SLTI, 2, 15, 16'hffff), 1, 1, 15, 32'h0000_0001);
        add_entry(itype_word(O_SLTIU, 1, 16, 16'hffff), 1, 1, 16, 32'h0000_0001);
        add_entry(itype_word(O_ANDI, 2, 17, 16'h8001), 1, 1, 17, 32'h0000_8000);
        add_entry(itype_word(O_XORI, 17, 18, 16'hffff), 1, 1, 18, 32'h0000_7fff);
        add_entry(itype_word(O_ORI, 18, 19, 16'h8000), 1, 1, 19, 32'h0000_ffff);
        add_entry(rtype_word(1, 1, 0, 0, F_ADDU), 1, 0, 0, 32'h0);
        add_entry(itype_word(O_ADDIU, 0, 20, 16'h0005), 1, 1, 20, 32'h0000_0005);
        // -2 * 0x1234, then the unsigned view of the same operands
        add_entry(rtype_word(2, 1, 0, 0, F_MULT), 1, 0, 0, 32'h0);
        add_entry(rtype_word(0, 0, 21, 0, F_MFHI), 1, 1, 21, 32'hffff_ffff);
        add_entry(rtype_word(0, 0, 22, 0, F_MFLO), 1, 1, 22, 32'hffff_db98);
        add_entry(rtype_word(2, 1, 0, 0, F_MULTU), 1, 0, 0, 32'h0);
        add_entry(rtype_word(0, 0, 23, 0, F_MFLO), 1, 1, 23, 32'hffff_db98);
        add_entry(rtype_word(0, 0, 24, 0, F_MFHI), 1, 1, 24, 32'h0000_1233);
        add_entry(rtype_word(11, 0, 0, 0, F_MTHI), 1, 0, 0, 32'h0);
        add_entry(rtype_word(20, 0, 0, 0, F_MTLO), 1, 0, 0, 32'h0);
        add_entry(rtype_word(0, 0, 25, 0, F_MFHI), 1, 1, 25, 32'h8000_0000);
        add_entry(rtype_word(0, 0, 26, 0, F_MFLO), 1, 1, 26, 32'h0000_0005);
        // lw and add are not supported
        add_entry(itype_word(6'h23, 1, 27, 16'h0000), 1, 0, 0, 32'h0);
        add_entry(rtype_word(1, 1, 27, 0, 6'h20), 1, 0, 0, 32'h0);
        add_entry(rtype_word(1, 1, 27, 0, F_ADDU), 0, 0, 0, 32'h0);
        add_entry(rtype_word(27, 1, 27, 0, F_ADDU), 1, 1, 27, 32'h0000_1234);
        add_entry(rtype_word(27, 27, 28, 0, F_ADDU), 1, 1, 28, 32'h0000_2468);
        add_entry(rtype_word(28, 27, 29, 0, F_SUBU), 1, 1, 29, 32'h0000_1234);
        add_entry(rtype_word(29, 29, 0, 0, F_ADDU), 1, 0, 0, 32'h0);
        add_entry(rtype_word(0, 29, 30, 0, F_OR), 1, 1, 30, 32'h0000_1234);
        add_entry(rtype_word(11, 14, 31, 0, F_SLTU), 1, 1, 31, 32'h0000_0001);
        add_entry(rtype_word(14, 11, 9, 0, F_SLT), 1, 1, 9, 32'h0000_0000);
    endtask

    task automatic compare_port();
        int k;
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            k = idx_q.pop_front();
            due_q.delete(0);
            check_value(wb_valid, exp_v_tab[k], $sformatf("wb_valid of entry %0d", k));
            if (exp_v_tab[k]) begin
                check_value(wb_addr, exp_a_tab[k], $sformatf("wb_addr of entry %0d", k));
                check_value(wb_data, exp_d_tab[k], $sformatf("wb_data of entry %0d", k));
            end
        end else begin
            check_value(wb_valid, 1'b0, "wb_valid with no write due");
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // mid-cycle sampling, the port is stable here
    always @(negedge clk) begin
        check_value(u_mini_core.u_core_sva.fail_count, 0, "count of failed assertions");
        if (!reset) begin
            compare_port();
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr = '0;
        void'($urandom(32'hc2e9));
        build_table();
        cycle_limit = 2 * entry_count + 50;
        @(negedge reset);
        for (int i = 0; i < entry_count; i++) begin
            @(posedge clk);
            #1;
            instr = instr_tab[i];
            instr_valid = valid_tab[i];
            idx_q.push_back(i);
            due_q.push_back(cycle + 2);
            // a product is always read back on the very next cycle
            if (!is_product_op(instr_tab[i]) && $urandom % 4 == 0) begin
                @(posedge clk);
                #1;
                instr_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
